// ==== source/blur_kernel.sv ====
// registered 1-2-1 gaussian smoothing of a 3x3 pixel window, one result per channel
`include "image_consts.svh"

module blur_kernel (
	input logic clk,
	input logic reset_n,
	input pixel_pkg::window_t window,
	output pixel_pkg::pixel_t blurred
);
	// weights add to 16, so four extra bits hold the sum
	logic [`CHAN_BITS+3:0] sum_red;
	logic [`CHAN_BITS+3:0] sum_green;
	logic [`CHAN_BITS+3:0] sum_blue;

	// weight is 1 at corners, 2 on edges, 4 at centre, applied as a shift
	always_comb begin
		sum_red = '0;
		sum_green = '0;
		sum_blue = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				sum_red = sum_red
					+ ({4'b0, window[r][c].red} << (int'(r == 1) + int'(c == 1)));
				sum_green = sum_green
					+ ({4'b0, window[r][c].green} << (int'(r == 1) + int'(c == 1)));
				sum_blue = sum_blue
					+ ({4'b0, window[r][c].blue} << (int'(r == 1) + int'(c == 1)));
			end
		end
	end

	// divide by 16 by dropping the low bits
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			blurred <= '0;
		end else begin
			blurred <= '{
				red: sum_red[`CHAN_BITS+3:4],
				green: sum_green[`CHAN_BITS+3:4],
				blue: sum_blue[`CHAN_BITS+3:4],
				pad: '0
			};
		end
	end

endmodule

// ==== source/bus_pkg.sv ====
// memory bus request and response types shared by the master and its memory
`include "image_consts.svh"

package bus_pkg;

	// byte address on the bus
	typedef logic [`ADDR_BITS-1:0] mem_addr_t;

	// one data word
	typedef logic [31:0] mem_word_t;

	// master to memory, held steady while waitrequest is high
	typedef struct packed {
		mem_addr_t address;
		mem_word_t writedata;
		logic read;
		logic write;
	} mem_req_t;

	// memory to master
	typedef struct packed {
		mem_word_t readdata;
		logic readdatavalid;
		logic waitrequest;
	} mem_rsp_t;

endpackage

// ==== source/image_consts.svh ====
// frame geometry, base addresses and word sizes; include wherever these constants are needed
`ifndef IMAGE_CONSTS_SVH
`define IMAGE_CONSTS_SVH

// frame geometry in pixels
`define IMG_WIDTH 8
`define IMG_HEIGHT 6

// one pixel per bus word
`define WORD_BYTES 4

// byte distance between vertically adjacent pixels
`define ROW_STRIDE (`IMG_WIDTH * `WORD_BYTES)

// source frame in upper sdram region, filtered frame at bottom
`define SRC_BASE 32'h0812_C000
`define DST_BASE 32'h0800_0000

// bus address width
`define ADDR_BITS 32

// bits per colour channel
`define CHAN_BITS 8

`endif

// ==== source/image_filter_top.sv ====
// top of the image filter engine; connects the controller, addresser and datapath blocks
module image_filter_top (
	input logic clk,
	input logic reset_n,
	input pixel_pkg::filter_mode_t filter_mode,
	output logic pass_done,
	output bus_pkg::mem_req_t mem_req,
	input bus_pkg::mem_rsp_t mem_rsp
);
	import bus_pkg::*;
	import pixel_pkg::*;

	// addresser handshake
	mem_addr_t rd_addr;
	mem_addr_t wr_addr;
	logic row_last;
	logic frame_last;
	logic frame_start;
	logic col_step;
	logic row_step;
	row_sel_t row_sel;

	// window and datapath
	logic load;
	logic shift;
	pixel_t load_pixel;
	window_t window;
	pixel_t blurred;
	pixel_t invert_in;
	pixel_t inverted;

	// sequencing and sole bus driver
	pass_controller pass_controller_inst (
		.clk(clk),
		.reset_n(reset_n),
		.filter_mode(filter_mode),
		.pass_done(pass_done),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.rd_addr(rd_addr),
		.wr_addr(wr_addr),
		.row_last(row_last),
		.frame_last(frame_last),
		.frame_start(frame_start),
		.col_step(col_step),
		.row_step(row_step),
		.row_sel(row_sel),
		.load(load),
		.shift(shift),
		.load_pixel(load_pixel),
		.blurred(blurred),
		.inverted(inverted),
		.invert_in(invert_in)
	);

	window_addresser window_addresser_inst (
		.clk(clk),
		.reset_n(reset_n),
		.frame_start(frame_start),
		.col_step(col_step),
		.row_step(row_step),
		.row_sel(row_sel),
		.rd_addr(rd_addr),
		.wr_addr(wr_addr),
		.row_last(row_last),
		.frame_last(frame_last)
	);

	window_buffer window_buffer_inst (
		.clk(clk),
		.reset_n(reset_n),
		.load(load),
		.shift(shift),
		.row_sel(row_sel),
		.load_pixel(load_pixel),
		.window(window)
	);

	blur_kernel blur_kernel_inst (
		.clk(clk),
		.reset_n(reset_n),
		.window(window),
		.blurred(blurred)
	);

	pixel_invert pixel_invert_inst (
		.clk(clk),
		.reset_n(reset_n),
		.invert_in(invert_in),
		.inverted(inverted)
	);

endmodule

// ==== source/pass_controller.sv ====
// pass sequencer; runs the invert or blur pass and is the only driver of the memory bus master
`include "image_consts.svh"

module pass_controller (
	input logic clk,
	input logic reset_n,
	input pixel_pkg::filter_mode_t filter_mode,
	output logic pass_done,
	output bus_pkg::mem_req_t mem_req,
	input bus_pkg::mem_rsp_t mem_rsp,
	input bus_pkg::mem_addr_t rd_addr,
	input bus_pkg::mem_addr_t wr_addr,
	input logic row_last,
	input logic frame_last,
	output logic frame_start,
	output logic col_step,
	output logic row_step,
	output pixel_pkg::row_sel_t row_sel,
	output logic load,
	output logic shift,
	output pixel_pkg::pixel_t load_pixel,
	input pixel_pkg::pixel_t blurred,
	input pixel_pkg::pixel_t inverted,
	output pixel_pkg::pixel_t invert_in
);
	import bus_pkg::*;
	import pixel_pkg::*;

	// byte offset of the final pixel word in a frame
	localparam mem_addr_t LAST_OFFSET = mem_addr_t'((`IMG_WIDTH * `IMG_HEIGHT - 1) * `WORD_BYTES);

	typedef enum logic [3:0] {
		st_idle,
		st_inv_read,
		st_inv_wait,
		st_inv_calc,
		st_inv_write,
		st_col_read,
		st_col_wait,
		st_col_shift,
		st_kernel,
		st_blur_write,
		st_done
	} state_t;

	state_t state;
	// invert pass walks both frames with one offset
	mem_addr_t inv_offset;
	// columns shifted in since the row started, saturates at 3
	logic [1:0] fill_cnt;
	// read word kept for the invert stage
	pixel_t rd_word;
	logic accepted;

	assign accepted = !mem_rsp.waitrequest;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= st_idle;
			inv_offset <= '0;
			fill_cnt <= '0;
			row_sel <= row_bot;
		end else begin
			case (state)
				st_idle: begin
					inv_offset <= '0;
					fill_cnt <= '0;
					row_sel <= row_bot;
					if (filter_mode == mode_invert)
						state <= st_inv_read;
					else if (filter_mode == mode_blur)
						state <= st_col_read;
				end
				st_inv_read: begin
					if (accepted)
						state <= st_inv_wait;
				end
				st_inv_wait: begin
					if (mem_rsp.readdatavalid)
						state <= st_inv_calc;
				end
				// pixel_invert registers its result here
				st_inv_calc: begin
					state <= st_inv_write;
				end
				st_inv_write: begin
					if (accepted) begin
						if (inv_offset == LAST_OFFSET) begin
							state <= st_done;
						end else begin
							inv_offset <= inv_offset + mem_addr_t'(`WORD_BYTES);
							state <= st_inv_read;
						end
					end
				end
				st_col_read: begin
					if (accepted)
						state <= st_col_wait;
				end
				// column is read bottom, middle, then top
				st_col_wait: begin
					if (mem_rsp.readdatavalid) begin
						case (row_sel)
							row_bot: row_sel <= row_mid;
							row_mid: row_sel <= row_top;
							default: row_sel <= row_bot;
						endcase
						state <= (row_sel == row_top) ? st_col_shift : st_col_read;
					end
				end
				// three columns needed before the first output of a row
				st_col_shift: begin
					if (fill_cnt != 2'd3)
						fill_cnt <= fill_cnt + 2'd1;
					state <= (fill_cnt >= 2'd2) ? st_kernel : st_col_read;
				end
				// blur_kernel registers its result here
				st_kernel: begin
					state <= st_blur_write;
				end
				st_blur_write: begin
					if (accepted) begin
						if (!row_last) begin
							state <= st_col_read;
						end else if (frame_last) begin
							state <= st_done;
						end else begin
							fill_cnt <= '0;
							state <= st_col_read;
						end
					end
				end
				// hold until the mode input is released
				st_done: begin
					if (filter_mode == mode_none)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_inv_wait && mem_rsp.readdatavalid)
			rd_word <= mem_rsp.readdata;
	end

	assign invert_in = rd_word;
	// window loads straight from the returning read data
	assign load_pixel = mem_rsp.readdata;
	assign load = (state == st_col_wait) && mem_rsp.readdatavalid;
	assign shift = (state == st_col_shift);
	assign col_step = (state == st_col_shift);
	assign frame_start = (state == st_idle) && (filter_mode == mode_blur);
	assign row_step = (state == st_blur_write) && accepted && row_last && !frame_last;
	assign pass_done = (state == st_done);

	// request fields depend only on state, so they stay put under waitrequest
	always_comb begin
		mem_req = '0;
		case (state)
			st_inv_read: begin
				mem_req.address = `SRC_BASE + inv_offset;
				mem_req.read = 1'b1;
			end
			st_inv_write: begin
				mem_req.address = `DST_BASE + inv_offset;
				mem_req.writedata = inverted;
				mem_req.write = 1'b1;
			end
			st_col_read: begin
				mem_req.address = rd_addr;
				mem_req.read = 1'b1;
			end
			st_blur_write: begin
				mem_req.address = wr_addr;
				mem_req.writedata = blurred;
				mem_req.write = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// ==== source/pixel_invert.sv ====
// registered colour complement of one pixel word for the invert pass
module pixel_invert (
	input logic clk,
	input logic reset_n,
	input pixel_pkg::pixel_t invert_in,
	output pixel_pkg::pixel_t inverted
);
	// 255 minus an 8-bit channel is its bitwise complement
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			inverted <= '0;
		end else begin
			inverted <= '{
				red: ~invert_in.red,
				green: ~invert_in.green,
				blue: ~invert_in.blue,
				pad: '0
			};
		end
	end

endmodule

// ==== source/pixel_pkg.sv ====
// pixel, window and mode types used by the filter datapath and its controller
`include "image_consts.svh"

package pixel_pkg;

	// one colour channel
	typedef logic [`CHAN_BITS-1:0] channel_t;

	// same layout as a memory word, colour in the top three bytes
	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
		channel_t pad;
	} pixel_t;

	// first index is row (top, mid, bot), second is column (left, centre, right)
	typedef pixel_t [0:2][0:2] window_t;

	// values double as the row offset from the window top
	typedef enum logic [1:0] {
		row_top,
		row_mid,
		row_bot
	} row_sel_t;

	// pass selection, held as a level
	typedef enum logic [1:0] {
		mode_none,
		mode_invert,
		mode_blur
	} filter_mode_t;

endpackage

// ==== source/window_addresser.sv ====
// tracks window row and read column during the blur pass and forms its bus addresses
`include "image_consts.svh"

module window_addresser (
	input logic clk,
	input logic reset_n,
	input logic frame_start,
	input logic col_step,
	input logic row_step,
	input pixel_pkg::row_sel_t row_sel,
	output bus_pkg::mem_addr_t rd_addr,
	output bus_pkg::mem_addr_t wr_addr,
	output logic row_last,
	output logic frame_last
);
	import bus_pkg::*;

	// column counter reaches the width itself after the last load
	localparam int COL_BITS = $clog2(`IMG_WIDTH + 1);
	localparam int ROW_BITS = $clog2(`IMG_HEIGHT);

	// next column to read
	logic [COL_BITS-1:0] col;
	// source row at the window top
	logic [ROW_BITS-1:0] top_row;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			col <= '0;
			top_row <= '0;
		end else if (frame_start) begin
			col <= '0;
			top_row <= '0;
		end else if (row_step) begin
			col <= '0;
			top_row <= top_row + 1'b1;
		end else if (col_step) begin
			col <= col + 1'b1;
		end
	end

	// row_sel encodes the offset below the window top
	assign rd_addr = `SRC_BASE
		+ (mem_addr_t'(top_row) + mem_addr_t'(row_sel)) * `ROW_STRIDE
		+ mem_addr_t'(col) * `WORD_BYTES;

	// centre sits two columns behind the read column once the window is full
	assign wr_addr = `DST_BASE
		+ (mem_addr_t'(top_row) + mem_addr_t'(1)) * `ROW_STRIDE
		+ (mem_addr_t'(col) - mem_addr_t'(2)) * `WORD_BYTES;

	// centre at the last interior column
	assign row_last = (col == COL_BITS'(`IMG_WIDTH));
	// middle row at the last interior row
	assign frame_last = (top_row == ROW_BITS'(`IMG_HEIGHT - 3));

endmodule

// ==== source/window_buffer.sv ====
// three rows of four pixel slots; columns enter on the right and move left to form the window
module window_buffer (
	input logic clk,
	input logic reset_n,
	input logic load,
	input logic shift,
	input pixel_pkg::row_sel_t row_sel,
	input pixel_pkg::pixel_t load_pixel,
	output pixel_pkg::window_t window
);
	import pixel_pkg::*;

	// slot 3 takes the incoming column
	pixel_t [0:2][0:3] slots;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			slots <= '0;
		end else if (load) begin
			slots[row_sel][3] <= load_pixel;
		end else if (shift) begin
			// incoming column becomes the right edge
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					slots[r][c] <= slots[r][c + 1];
				end
			end
		end
	end

	// window is the left three slots of each row
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			window[r] = slots[r][0:2];
		end
	end

endmodule

// ==== src.f ====
+incdir+source
source/bus_pkg.sv
source/pixel_pkg.sv
source/pass_controller.sv
source/window_addresser.sv
source/window_buffer.sv
source/blur_kernel.sv
source/pixel_invert.sv
source/image_filter_top.sv
tb/sdram_model.sv
tb/image_filter_tb.sv

// ==== tb/image_filter_tb.sv ====
// testbench for the image filter engine; runs an invert then a blur pass against an sdram model
`include "image_consts.svh"

module image_filter_tb;
	import bus_pkg::*;
	import pixel_pkg::*;

	localparam int W = `IMG_WIDTH;
	localparam int H = `IMG_HEIGHT;
	localparam int WORDS = W * H;
	// two passes, each word up to 8 transfers of 8 cycles, plus margin
	localparam int TIMEOUT_CYCLES = 2 * WORDS * 8 * 8 + 2000;

	logic clk;
	logic reset_n;
	filter_mode_t filter_mode;
	logic pass_done;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	int error_count;
	int check_count;
	int write_count;
	int cycle_count;
	// destination words hit in the current pass
	logic [WORDS-1:0] written;
	pixel_t shadow [0:WORDS-1];
	// monitor history from the previous edge
	logic reset_prev;
	int reset_cycles;
	logic read_open;
	logic hold_req;
	mem_req_t held_req;
	logic done_prev;
	filter_mode_t mode_prev;

	image_filter_top image_filter_top_inst (
		.clk(clk),
		.reset_n(reset_n),
		.filter_mode(filter_mode),
		.pass_done(pass_done),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	sdram_model sdram_model_inst (
		.clk(clk),
		.reset_n(reset_n),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	always #10 clk = ~clk;

	task automatic expect_equal(input string name, input logic [$bits(mem_req_t)-1:0] expected,
			input logic [$bits(mem_req_t)-1:0] actual);
		check_count++;
		assert (expected === actual) else begin
			error_count++;
			$display("FAILED t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		check_count++;
		assert (cond === 1'b1) else begin
			error_count++;
			$display("error at t=%0t: %s", $time, what);
		end
	endtask

	// each channel becomes 255 minus itself, pad cleared
	function automatic pixel_t invert_rule(input pixel_t p);
		return '{red: 8'd255 - p.red, green: 8'd255 - p.green, blue: 8'd255 - p.blue, pad: 8'd0};
	endfunction

	// 1-2-1 in both directions, sum over 16 truncated
	function automatic pixel_t blur_rule(input int x, input int y);
		int weight;
		int sum_r;
		int sum_g;
		int sum_b;
		pixel_t p;
		sum_r = 0;
		sum_g = 0;
		sum_b = 0;
		for (int dy = -1; dy <= 1; dy++) begin
			for (int dx = -1; dx <= 1; dx++) begin
				weight = (2 - (dx < 0 ? -dx : dx)) * (2 - (dy < 0 ? -dy : dy));
				p = shadow[(y + dy) * W + x + dx];
				sum_r += weight * int'(p.red);
				sum_g += weight * int'(p.green);
				sum_b += weight * int'(p.blue);
			end
		end
		return '{red: 8'(sum_r / 16), green: 8'(sum_g / 16), blue: 8'(sum_b / 16), pad: 8'd0};
	endfunction

	// accepted write, checked against the pass selected by filter_mode
	task automatic record_write();
		mem_addr_t offset;
		int idx;
		int x;
		int y;
		offset = mem_req.address - `DST_BASE;
		if (offset >= WORDS * `WORD_BYTES || offset[1:0] != 2'b00) begin
			expect_true(1'b0, "write outside the destination frame");
		end else begin
			idx = offset / `WORD_BYTES;
			x = idx % W;
			y = idx / W;
			expect_true(!written[idx], "destination word written twice in one pass");
			written[idx] = 1'b1;
			write_count++;
			if (filter_mode == mode_invert)
				expect_equal("mem_req.writedata", invert_rule(shadow[idx]), mem_req.writedata);
			else if (filter_mode == mode_blur && x > 0 && x < W - 1 && y > 0 && y < H - 1)
				expect_equal("mem_req.writedata", blur_rule(x, y), mem_req.writedata);
			else
				expect_true(1'b0, "write to a border pixel or with no pass selected");
		end
	endtask

	always @(posedge clk) begin : bus_monitor
		mem_addr_t offset;
		if (!reset_n)
			reset_cycles++;
		// the very first edge still sees an unreset engine
		if ((!reset_n && reset_cycles > 1) || (reset_n && !reset_prev)) begin
			expect_equal("mem_req.read", 0, mem_req.read);
			expect_equal("mem_req.write", 0, mem_req.write);
			expect_equal("pass_done", 0, pass_done);
		end
		reset_prev = reset_n;
		if (reset_n) begin
			expect_true(!(mem_req.read && mem_req.write), "read and write high together");
			if (hold_req)
				expect_equal("mem_req", held_req, mem_req);
			if (mem_req.read) begin
				expect_true(!read_open, "new read issued while a read is outstanding");
				offset = mem_req.address - `SRC_BASE;
				expect_true(offset < WORDS * `WORD_BYTES && offset[1:0] == 2'b00,
					"read outside the source frame");
			end
			// done may only drop once the mode is released
			if (done_prev && mode_prev != mode_none)
				expect_equal("pass_done", 1, pass_done);
			if (mem_req.write && !mem_rsp.waitrequest)
				record_write();
			hold_req = (mem_req.read || mem_req.write) && mem_rsp.waitrequest;
			held_req = mem_req;
			if (mem_rsp.readdatavalid)
				read_open = 1'b0;
			if (mem_req.read && !mem_rsp.waitrequest)
				read_open = 1'b1;
			done_prev = pass_done;
			mode_prev = filter_mode;
		end
	end

	// start a pass, wait for done, hold the mode a while, then release
	task automatic run_pass(input filter_mode_t mode, input int expected_writes);
		write_count = 0;
		written = '0;
		filter_mode <= mode;
		@(posedge clk);
		while (!pass_done)
			@(posedge clk);
		repeat (3) @(posedge clk);
		expect_equal("write count", expected_writes, write_count);
		filter_mode <= mode_none;
		repeat (2) @(posedge clk);
		expect_equal("pass_done", 0, pass_done);
		repeat (2) @(posedge clk);
	endtask

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		filter_mode = mode_none;
		error_count = 0;
		check_count = 0;
		write_count = 0;
		written = '0;
		reset_prev = 1'b0;
		reset_cycles = 0;
		read_open = 1'b0;
		hold_req = 1'b0;
		held_req = '0;
		done_prev = 1'b0;
		mode_prev = mode_none;
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		// source frame as preloaded into the model
		for (int i = 0; i < WORDS; i++)
			shadow[i] = sdram_model_inst.src_mem[i];
		repeat (3) @(posedge clk);
		run_pass(mode_invert, WORDS);
		run_pass(mode_blur, (W - 2) * (H - 2));
		$display("checks %0d, errors %0d, cycles %0d", check_count, error_count, cycle_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// watchdog on the cycle count
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: passes did not finish within %0d cycles, errors %0d",
			TIMEOUT_CYCLES, error_count);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== tb/sdram_model.sv ====
// behavioural sdram for the filter testbench; random waitrequest and read latency, source preloaded
`include "image_consts.svh"

module sdram_model #(
	parameter logic [31:0] SEED = 32'ha714_d49e
) (
	input logic clk,
	input logic reset_n,
	input bus_pkg::mem_req_t mem_req,
	output bus_pkg::mem_rsp_t mem_rsp
);
	import bus_pkg::*;

	localparam int WORDS = `IMG_WIDTH * `IMG_HEIGHT;

	// word indexed frames
	logic [31:0] src_mem [0:WORDS-1];
	logic [31:0] dst_mem [0:WORDS-1];
	logic [31:0] rng;
	// one read in flight at most
	logic pending;
	int latency;
	mem_addr_t pend_addr;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// outside both frames a read returns the inverted address
	function automatic mem_word_t fetch_word(input mem_addr_t addr);
		mem_addr_t src_idx;
		mem_addr_t dst_idx;
		src_idx = (addr - `SRC_BASE) / `WORD_BYTES;
		dst_idx = (addr - `DST_BASE) / `WORD_BYTES;
		if (src_idx < WORDS)
			return src_mem[src_idx];
		else if (dst_idx < WORDS)
			return dst_mem[dst_idx];
		return ~addr;
	endfunction

	initial begin
		rng = SEED;
		for (int i = 0; i < WORDS; i++) begin
			rng = xorshift32(rng);
			src_mem[i] = rng;
			// destination starts out holding its own address
			dst_mem[i] = `DST_BASE + i * `WORD_BYTES;
		end
		pending = 1'b0;
		latency = 0;
		pend_addr = '0;
		mem_rsp = '{readdata: '0, readdatavalid: 1'b0, waitrequest: 1'b1};
	end

	always @(posedge clk) begin : respond
		mem_addr_t wr_idx;
		rng = xorshift32(rng);
		wr_idx = (mem_req.address - `DST_BASE) / `WORD_BYTES;
		if (!reset_n) begin
			pending <= 1'b0;
			mem_rsp <= '{readdata: '0, readdatavalid: 1'b0, waitrequest: 1'b1};
		end else begin
			mem_rsp.readdatavalid <= 1'b0;
			if (pending) begin
				if (latency == 1) begin
					mem_rsp.readdata <= fetch_word(pend_addr);
					mem_rsp.readdatavalid <= 1'b1;
					pending <= 1'b0;
				end
				latency <= latency - 1;
			end
			// latency of 1 to 4 cycles from the accepting edge
			if (mem_req.read && !mem_rsp.waitrequest) begin
				pending <= 1'b1;
				latency <= 1 + int'(rng[9:8]);
				pend_addr <= mem_req.address;
			end
			if (mem_req.write && !mem_rsp.waitrequest && wr_idx < WORDS)
				dst_mem[wr_idx] <= mem_req.writedata;
			// stall about three cycles in eight
			mem_rsp.waitrequest <= (rng[2:0] < 3'd3);
		end
	end

endmodule
